//--- rtl/tft_pkg.sv
package tft_pkg;

  // panel geometry, landscape 320 x 240
  localparam logic [8:0] SCREEN_W = 9'd320;
  localparam logic [8:0] SCREEN_H = 9'd240;

  // pixel coordinates
  typedef logic [8:0]  coord_x_t;
  typedef logic [7:0]  coord_y_t;

  // rgb565, red in the top five bits
  typedef logic [15:0] color_t;

  // one byte on the 8080 data bus
  typedef logic [7:0]  tft_byte_t;

  // up to 320 * 240 = 76800 pixels
  typedef logic [16:0] pixel_count_t;

  // one fill request, bounds inclusive
  typedef struct packed {
    coord_x_t x_start;
    coord_x_t x_end;
    coord_y_t y_start;
    coord_y_t y_end;
    color_t   color;
  } rect_t;

  // byte plus its command/data flag
  // cd high means data, low means command
  typedef struct packed {
    logic      cd;
    tft_byte_t data;
  } bus_word_t;

  // panel command set
  localparam tft_byte_t CMD_SWRESET   = 8'h01;
  localparam tft_byte_t CMD_DISPOFF   = 8'h28;
  localparam tft_byte_t CMD_COLMOD    = 8'h3A;
  localparam tft_byte_t COLMOD_RGB565 = 8'h55;
  localparam tft_byte_t CMD_SLPOUT    = 8'h11;
  localparam tft_byte_t CMD_DISPON    = 8'h29;
  localparam tft_byte_t CMD_CASET     = 8'h2A;
  localparam tft_byte_t CMD_PASET     = 8'h2B;
  localparam tft_byte_t CMD_RAMWR     = 8'h2C;

  // command sequencer
  typedef enum logic [3:0] {
    SEQ_INIT_WORD,
    SEQ_INIT_WAIT,
    SEQ_IDLE,
    SEQ_COL_CMD,
    SEQ_COL_DATA,
    SEQ_ROW_CMD,
    SEQ_ROW_DATA,
    SEQ_MEM_CMD,
    SEQ_PIXEL
  } seq_state_t;

  // bus writer strobe phases
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_LOW,
    BUS_HIGH
  } bus_state_t;

endpackage

//--- rtl/rect_queue.sv
`timescale 1ns/1ps

module rect_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           req_valid,
  input  tft_pkg::rect_t req,
  input  logic           take,
  output tft_pkg::rect_t head,
  output logic           head_valid,
  output logic           credit_return
);

  // pointer and occupancy widths
  localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CW = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PW-1:0] PTR_LAST = PW'(QUEUE_DEPTH - 1);
  localparam logic [CW-1:0] CNT_FULL = CW'(QUEUE_DEPTH);

  tft_pkg::rect_t mem [QUEUE_DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          push;
  logic          pop;

  assign full       = (count == CNT_FULL);
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // credits keep the sender off a full queue
  assign push = req_valid && !full;
  assign pop  = take && head_valid;

  // request storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= req;
    end
  end

  // circular pointers, wrap works for any depth
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per entry handed on, one cycle late
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
    end
  end

  // sender spent a credit it did not hold
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n) req_valid |-> !full
  );

  // sequencer only starts a rectangle that is there
  a_no_take_empty: assert property (
    @(posedge clk) disable iff (!arst_n) take |-> head_valid
  );

  // ordered bounds, inside the panel
  a_req_bounds: assert property (
    @(posedge clk) disable iff (!arst_n)
    req_valid |-> (req.x_start <= req.x_end) && (req.x_end < tft_pkg::SCREEN_W) &&
                  (req.y_start <= req.y_end) && ({1'b0, req.y_end} < tft_pkg::SCREEN_H)
  );

endmodule

//--- rtl/tft_sequencer.sv
`timescale 1ns/1ps

module tft_sequencer #(
  parameter int INIT_DELAY = 250000
) (
  input  logic               clk,
  input  logic               arst_n,
  input  tft_pkg::rect_t     head,
  input  logic               head_valid,
  input  logic               word_ready,
  output logic               take,
  output tft_pkg::bus_word_t word,
  output logic               word_valid,
  output logic               init_done
);

  // delay counter runs 0 .. INIT_DELAY-1
  localparam int DW = (INIT_DELAY > 1) ? $clog2(INIT_DELAY) : 1;
  localparam logic [DW-1:0] DELAY_LAST = DW'(INIT_DELAY - 1);
  // index of the display on word
  localparam logic [2:0] INIT_LAST = 3'd5;

  tft_pkg::seq_state_t   state;
  tft_pkg::bus_word_t    init_word;
  tft_pkg::rect_t        cur;
  tft_pkg::coord_x_t     rect_w;
  tft_pkg::coord_y_t     rect_h;
  tft_pkg::pixel_count_t rect_pixels;
  tft_pkg::pixel_count_t pix_left;
  logic [2:0]            init_idx;
  logic [1:0]            sub;
  logic [DW-1:0]         delay_cnt;
  logic                  moved;
  logic                  init_pause;

  assign moved = word_valid && word_ready;

  // power-up command list
  always_comb begin
    init_word.cd = 1'b0;
    case (init_idx)
      3'd0:    init_word.data = tft_pkg::CMD_SWRESET;
      3'd1:    init_word.data = tft_pkg::CMD_DISPOFF;
      3'd2:    init_word.data = tft_pkg::CMD_COLMOD;
      3'd3: begin
        // pixel format argument
        init_word.cd   = 1'b1;
        init_word.data = tft_pkg::COLMOD_RGB565;
      end
      3'd4:    init_word.data = tft_pkg::CMD_SLPOUT;
      default: init_word.data = tft_pkg::CMD_DISPON;
    endcase
  end

  // panel needs a pause after soft reset and sleep out
  assign init_pause = !init_word.cd &&
                      ((init_word.data == tft_pkg::CMD_SWRESET) ||
                       (init_word.data == tft_pkg::CMD_SLPOUT));

  // inclusive size of the waiting rectangle
  assign rect_w      = head.x_end - head.x_start + 1'b1;
  assign rect_h      = head.y_end - head.y_start + 1'b1;
  assign rect_pixels = tft_pkg::pixel_count_t'(rect_w) * tft_pkg::pixel_count_t'(rect_h);

  // start a rectangle as soon as one waits
  assign take = (state == tft_pkg::SEQ_IDLE) && head_valid;

  // outgoing word, held until accepted
  always_comb begin
    word.cd    = 1'b1;
    word.data  = '0;
    word_valid = 1'b1;
    case (state)
      tft_pkg::SEQ_INIT_WORD: word = init_word;
      tft_pkg::SEQ_COL_CMD: begin
        word.cd   = 1'b0;
        word.data = tft_pkg::CMD_CASET;
      end
      tft_pkg::SEQ_COL_DATA: begin
        // panel is rotated, columns run along y
        case (sub)
          2'd1:    word.data = cur.y_start;
          2'd3:    word.data = cur.y_end;
          default: word.data = '0;
        endcase
      end
      tft_pkg::SEQ_ROW_CMD: begin
        word.cd   = 1'b0;
        word.data = tft_pkg::CMD_PASET;
      end
      tft_pkg::SEQ_ROW_DATA: begin
        // x needs nine bits, msb goes in its own byte
        case (sub)
          2'd0:    word.data = {7'b0, cur.x_start[8]};
          2'd1:    word.data = cur.x_start[7:0];
          2'd2:    word.data = {7'b0, cur.x_end[8]};
          default: word.data = cur.x_end[7:0];
        endcase
      end
      tft_pkg::SEQ_MEM_CMD: begin
        word.cd   = 1'b0;
        word.data = tft_pkg::CMD_RAMWR;
      end
      tft_pkg::SEQ_PIXEL: begin
        // high byte first
        word.data = sub[0] ? cur.color[7:0] : cur.color[15:8];
      end
      default: word_valid = 1'b0;
    endcase
  end

  // rectangle under way
  always_ff @(posedge clk) begin
    if (take) begin
      cur <= head;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= tft_pkg::SEQ_INIT_WORD;
      init_idx  <= '0;
      sub       <= '0;
      delay_cnt <= '0;
      pix_left  <= '0;
      init_done <= 1'b0;
    end else begin
      case (state)
        tft_pkg::SEQ_INIT_WORD: begin
          if (moved) begin
            if (init_idx == INIT_LAST) begin
              // display on taken, panel is up
              init_done <= 1'b1;
              state     <= tft_pkg::SEQ_IDLE;
            end else if (init_pause) begin
              delay_cnt <= '0;
              state     <= tft_pkg::SEQ_INIT_WAIT;
            end else begin
              init_idx <= init_idx + 1'b1;
            end
          end
        end
        tft_pkg::SEQ_INIT_WAIT: begin
          if (delay_cnt == DELAY_LAST) begin
            init_idx <= init_idx + 1'b1;
            state    <= tft_pkg::SEQ_INIT_WORD;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        tft_pkg::SEQ_IDLE: begin
          if (take) begin
            pix_left <= rect_pixels;
            state    <= tft_pkg::SEQ_COL_CMD;
          end
        end
        tft_pkg::SEQ_COL_CMD: begin
          if (moved) begin
            sub   <= '0;
            state <= tft_pkg::SEQ_COL_DATA;
          end
        end
        tft_pkg::SEQ_COL_DATA: begin
          if (moved) begin
            sub <= sub + 1'b1;
            if (sub == 2'd3) begin
              state <= tft_pkg::SEQ_ROW_CMD;
            end
          end
        end
        tft_pkg::SEQ_ROW_CMD: begin
          if (moved) begin
            sub   <= '0;
            state <= tft_pkg::SEQ_ROW_DATA;
          end
        end
        tft_pkg::SEQ_ROW_DATA: begin
          if (moved) begin
            sub <= sub + 1'b1;
            if (sub == 2'd3) begin
              state <= tft_pkg::SEQ_MEM_CMD;
            end
          end
        end
        tft_pkg::SEQ_MEM_CMD: begin
          if (moved) begin
            sub   <= '0;
            state <= tft_pkg::SEQ_PIXEL;
          end
        end
        tft_pkg::SEQ_PIXEL: begin
          if (moved) begin
            sub <= sub + 1'b1;
            // count pixels on the low byte
            if (sub[0]) begin
              if (pix_left == tft_pkg::pixel_count_t'(1)) begin
                state <= tft_pkg::SEQ_IDLE;
              end else begin
                pix_left <= pix_left - 1'b1;
              end
            end
          end
        end
        default: state <= tft_pkg::SEQ_INIT_WORD;
      endcase
    end
  end

  // offered word must not change under back-pressure
  a_word_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    word_valid && !word_ready |=> word_valid && $stable(word)
  );

endmodule

//--- rtl/bus_writer.sv
`timescale 1ns/1ps

module bus_writer (
  input  logic               clk,
  input  logic               arst_n,
  input  tft_pkg::bus_word_t word,
  input  logic               word_valid,
  output logic               word_ready,
  output logic               cs,
  output logic               cd,
  output logic               wr,
  output tft_pkg::tft_byte_t data
);

  tft_pkg::bus_state_t state;

  // new word only once the last strobe is done
  assign word_ready = (state == tft_pkg::BUS_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= tft_pkg::BUS_IDLE;
      cs    <= 1'b1;
      cd    <= 1'b1;
      wr    <= 1'b1;
      data  <= '0;
    end else begin
      case (state)
        tft_pkg::BUS_IDLE: begin
          if (word_valid) begin
            // select panel, drive byte, pull strobe low
            cs    <= 1'b0;
            cd    <= word.cd;
            data  <= word.data;
            wr    <= 1'b0;
            state <= tft_pkg::BUS_LOW;
          end
        end
        tft_pkg::BUS_LOW: begin
          // panel latches here
          wr    <= 1'b1;
          state <= tft_pkg::BUS_HIGH;
        end
        tft_pkg::BUS_HIGH: begin
          // data held one more cycle, then deselect
          cs    <= 1'b1;
          state <= tft_pkg::BUS_IDLE;
        end
        default: begin
          cs    <= 1'b1;
          wr    <= 1'b1;
          state <= tft_pkg::BUS_IDLE;
        end
      endcase
    end
  end

  // strobe only while selected
  a_wr_in_cs: assert property (
    @(posedge clk) disable iff (!arst_n) !wr |-> !cs
  );

endmodule

//--- rtl/tft_top.sv
`timescale 1ns/1ps

module tft_top #(
  parameter int QUEUE_DEPTH = 4,
  parameter int INIT_DELAY  = 250000
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               req_valid,
  input  tft_pkg::rect_t     req,
  output logic               credit_return,
  output logic               init_done,
  output logic               cs,
  output logic               cd,
  output logic               wr,
  output tft_pkg::tft_byte_t data
);

  // queue head towards sequencer
  tft_pkg::rect_t     head;
  logic               head_valid;
  logic               take;

  // byte stream towards bus writer
  tft_pkg::bus_word_t word;
  logic               word_valid;
  logic               word_ready;

  // credit-bounded request FIFO
  rect_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_rect_queue (
    .clk           (clk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req           (req),
    .take          (take),
    .head          (head),
    .head_valid    (head_valid),
    .credit_return (credit_return)
  );

  // power-up and rectangle expansion
  tft_sequencer #(
    .INIT_DELAY (INIT_DELAY)
  ) u_tft_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .head       (head),
    .head_valid (head_valid),
    .word_ready (word_ready),
    .take       (take),
    .word       (word),
    .word_valid (word_valid),
    .init_done  (init_done)
  );

  // 8080 write strobes to the pins
  bus_writer u_bus_writer (
    .clk        (clk),
    .arst_n     (arst_n),
    .word       (word),
    .word_valid (word_valid),
    .word_ready (word_ready),
    .cs         (cs),
    .cd         (cd),
    .wr         (wr),
    .data       (data)
  );

endmodule

//--- dv/tb_tft_checks.svh
`ifndef TB_TFT_CHECKS_SVH
`define TB_TFT_CHECKS_SVH

// galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_step();
  logic out;
  out  = lfsr[0];
  lfsr = lfsr >> 1;
  if (out) begin
    lfsr = lfsr ^ 16'hB400;
  end
  return out;
endfunction

// one lfsr step per bit taken, msb first
function automatic int rand_bits(input int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++) begin
    v = (v << 1) | int'(lfsr_step());
  end
  return v;
endfunction

function automatic tft_pkg::rect_t make_rect(input int xs, input int xe, input int ys,
                                             input int ye, input int color);
  tft_pkg::rect_t r;
  r.x_start = tft_pkg::coord_x_t'(xs);
  r.x_end   = tft_pkg::coord_x_t'(xe);
  r.y_start = tft_pkg::coord_y_t'(ys);
  r.y_end   = tft_pkg::coord_y_t'(ye);
  r.color   = tft_pkg::color_t'(color);
  return r;
endfunction

// at most 4 x 4, always inside 320 x 240
function automatic tft_pkg::rect_t random_rect();
  int xs;
  int xe;
  int ys;
  int ye;
  int color;
  xs    = rand_bits(9) % 317;
  xe    = xs + rand_bits(2);
  ys    = rand_bits(8) % 237;
  ye    = ys + rand_bits(2);
  color = rand_bits(16);
  return make_rect(xs, xe, ys, ye, color);
endfunction

function automatic void push_expected(input logic is_data, input tft_pkg::tft_byte_t b);
  exp_q.push_back({is_data, b});
endfunction

// power-up list, waits are invisible on the bus
function automatic void expect_power_up();
  push_expected(1'b0, tft_pkg::CMD_SWRESET);
  push_expected(1'b0, tft_pkg::CMD_DISPOFF);
  push_expected(1'b0, tft_pkg::CMD_COLMOD);
  push_expected(1'b1, tft_pkg::COLMOD_RGB565);
  push_expected(1'b0, tft_pkg::CMD_SLPOUT);
  push_expected(1'b0, tft_pkg::CMD_DISPON);
endfunction

// two window commands, memory write, then hi/lo color per pixel
function automatic void expect_rect(input tft_pkg::rect_t r);
  int npix;
  npix = (int'(r.x_end) - int'(r.x_start) + 1) * (int'(r.y_end) - int'(r.y_start) + 1);
  // columns carry y on this rotated panel
  push_expected(1'b0, tft_pkg::CMD_CASET);
  push_expected(1'b1, 8'h00);
  push_expected(1'b1, r.y_start);
  push_expected(1'b1, 8'h00);
  push_expected(1'b1, r.y_end);
  // rows carry x, bit 8 in a byte of its own
  push_expected(1'b0, tft_pkg::CMD_PASET);
  push_expected(1'b1, {7'b0, r.x_start[8]});
  push_expected(1'b1, r.x_start[7:0]);
  push_expected(1'b1, {7'b0, r.x_end[8]});
  push_expected(1'b1, r.x_end[7:0]);
  push_expected(1'b0, tft_pkg::CMD_RAMWR);
  for (int i = 0; i < npix; i++) begin
    push_expected(1'b1, r.color[15:8]);
    push_expected(1'b1, r.color[7:0]);
  end
endfunction

task automatic compare_word(input string name, input tft_pkg::bus_word_t got,
                            input tft_pkg::bus_word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t ns: %s is cd=%0b data=0x%02h, expected cd=%0b data=0x%02h",
             $time, name, got.cd, got.data, exp.cd, exp.data);
  end
endtask

task automatic compare_count(input string name, input int got, input int exp);
  checks++;
  if (got != exp) begin
    errors++;
    $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
  end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

`endif

//--- dv/tb_tft_top.sv
`timescale 1ns/1ps

module tb_tft_top;

  localparam int QUEUE_DEPTH = 4;
  localparam int INIT_DELAY  = 40;
  localparam int RESET_CYCLES = 16;
  // worst-case bus bytes for two power-ups, one 3x2 and fifteen 4x4 rectangles
  localparam int WORST_BYTES = 2 * 6 + (11 + 2 * 6) + 15 * (11 + 2 * 16);
  localparam int WATCHDOG_CYCLES =
    2 * (2 * WORST_BYTES + 2 * 2 * INIT_DELAY + 2 * RESET_CYCLES);

  logic               clk;
  logic               arst_n;
  logic               req_valid;
  tft_pkg::rect_t     req;
  logic               credit_return;
  logic               init_done;
  logic               cs;
  logic               cd;
  logic               wr;
  tft_pkg::tft_byte_t data;

  // scoreboard state
  tft_pkg::bus_word_t captured[$];
  int                 cap_cycle[$];
  tft_pkg::bus_word_t exp_q[$];
  int                 rd_idx;
  int                 cycle;
  int                 sent;
  int                 credits_back;
  int                 checks;
  int                 errors;
  int                 tests_run;
  logic [15:0]        lfsr;

  `include "tb_tft_checks.svh"

  tft_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .INIT_DELAY  (INIT_DELAY)
  ) dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .init_done     (init_done),
    .cs            (cs),
    .cd            (cd),
    .wr            (wr),
    .data          (data)
  );

  always #50 clk = ~clk;

  // cycle count and credits sampled mid-cycle
  always @(negedge clk) begin
    cycle++;
    if (arst_n === 1'b1 && credit_return === 1'b1) begin
      credits_back++;
    end
  end

  // panel latches on the rising strobe
  always @(posedge wr) begin
    if (arst_n === 1'b1) begin
      // chip select still held low on the rise
      compare_bit("cs at wr rise", cs, 1'b0);
      captured.push_back({cd, data});
      cap_cycle.push_back(cycle);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("[%0t ns] test %s: ok", $time, name);
    end else begin
      $display("[%0t ns] test %s: %0d errors", $time, name, errors - errs_before);
    end
  endtask

  task automatic clear_scoreboard();
    captured.delete();
    cap_cycle.delete();
    exp_q.delete();
    rd_idx       = 0;
    sent         = 0;
    credits_back = 0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    clear_scoreboard();
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  // one request per credit held
  task automatic send_rect(input tft_pkg::rect_t r);
    while (QUEUE_DEPTH - sent + credits_back == 0) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    sent++;
  endtask

  task automatic end_requests();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // wait for the expected words and compare them in order
  task automatic check_expected(input string tag);
    int need;
    int limit;
    int waited;
    need   = rd_idx + exp_q.size();
    limit  = 4 * exp_q.size() + 4 * INIT_DELAY + 100;
    waited = 0;
    while (captured.size() < need && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (captured.size() < need) begin
      errors++;
      $display("%s: timed out after %0d cycles with %0d of %0d bus words", tag, waited,
               captured.size() - rd_idx, exp_q.size());
    end
    foreach (exp_q[i]) begin
      if (rd_idx < captured.size()) begin
        compare_word($sformatf("%s word %0d", tag, i), captured[rd_idx], exp_q[i]);
        rd_idx++;
      end
    end
    exp_q.delete();
  endtask

  task automatic check_idle_pins(input string when);
    compare_bit({"cs ", when}, cs, 1'b1);
    compare_bit({"wr ", when}, wr, 1'b1);
    compare_bit({"cd ", when}, cd, 1'b1);
    compare_bit({"init_done ", when}, init_done, 1'b0);
    compare_bit({"credit_return ", when}, credit_return, 1'b0);
  endtask

  task automatic check_gap(input string what, input int gap);
    checks++;
    if (gap < INIT_DELAY) begin
      errors++;
      $display("at %0t ns: power-up wait %s lasted %0d cycles, needs at least %0d",
               $time, what, gap, INIT_DELAY);
    end
  endtask

  task automatic test_reset_values();
    int errs_before;
    errs_before = errors;
    arst_n <= 1'b0;
    clear_scoreboard();
    repeat (RESET_CYCLES / 2) @(posedge clk);
    @(negedge clk);
    check_idle_pins("during reset");
    repeat (RESET_CYCLES / 2) @(posedge clk);
    arst_n <= 1'b1;
    // nothing has been clocked out of reset yet
    @(negedge clk);
    check_idle_pins("after reset");
    report_test("reset_values", errs_before);
  endtask

  task automatic test_power_up_stream();
    int errs_before;
    errs_before = errors;
    expect_power_up();
    check_expected("power-up");
    compare_bit("init_done after display on", init_done, 1'b1);
    report_test("power_up_stream", errs_before);
  endtask

  task automatic test_power_up_waits();
    int errs_before;
    errs_before = errors;
    if (cap_cycle.size() < 6) begin
      errors++;
      $display("power-up waits: only %0d power-up words were captured", cap_cycle.size());
    end else begin
      check_gap("after software reset", cap_cycle[1] - cap_cycle[0]);
      check_gap("after sleep out", cap_cycle[5] - cap_cycle[4]);
    end
    report_test("power_up_waits", errs_before);
  endtask

  task automatic test_single_rect();
    int             errs_before;
    int             back_before;
    tft_pkg::rect_t r;
    errs_before = errors;
    back_before = credits_back;
    // x above 255 sets the high bit in the row window
    r = make_rect(300, 302, 10, 11, 16'hF800);
    expect_rect(r);
    send_rect(r);
    end_requests();
    check_expected("single rect");
    repeat (10) @(negedge clk);
    compare_count("bus words after single rect", captured.size(), rd_idx);
    compare_count("credits returned", credits_back - back_before, 1);
    report_test("single_rect", errs_before);
  endtask

  task automatic test_random_rects();
    int             errs_before;
    tft_pkg::rect_t r;
    errs_before = errors;
    for (int i = 0; i < 10; i++) begin
      r = random_rect();
      expect_rect(r);
      send_rect(r);
    end
    end_requests();
    check_expected("random rects");
    repeat (4) @(negedge clk);
    compare_count("credits returned vs sent", credits_back, sent);
    report_test("random_rects", errs_before);
  endtask

  task automatic test_queued_requests();
    int             errs_before;
    int             waited;
    int             first_done;
    tft_pkg::rect_t r[5];
    errs_before = errors;
    first_done  = 0;
    r[0] = make_rect(0, 3, 0, 3, 16'h001F);
    r[1] = make_rect(316, 319, 236, 239, 16'h07E0);
    r[2] = make_rect(100, 100, 50, 53, 16'hFFFF);
    r[3] = make_rect(255, 258, 120, 120, 16'h1234);
    r[4] = make_rect(12, 13, 200, 201, 16'hA5A5);
    apply_reset();
    expect_power_up();
    // fill every credit while the panel is still powering up
    for (int i = 0; i < 4; i++) begin
      expect_rect(r[i]);
      if (i == 0) begin
        first_done = exp_q.size();
      end
      send_rect(r[i]);
    end
    end_requests();
    @(negedge clk);
    compare_bit("init_done while queueing", init_done, 1'b0);
    waited = 0;
    while (init_done !== 1'b1 && waited < 4 * INIT_DELAY + 200) begin
      @(negedge clk);
      waited++;
    end
    if (init_done !== 1'b1) begin
      errors++;
      $display("queued requests: init_done did not rise after %0d cycles", waited);
    end
    compare_count("credits back before first take", credits_back, 0);
    // fifth has no credit until the queue hands one on
    expect_rect(r[4]);
    send_rect(r[4]);
    // credit comes back at the start of a rectangle, not at its end
    compare_bit("fifth request issued while first rect streams",
                captured.size() < first_done, 1'b1);
    end_requests();
    check_expected("queued rects");
    repeat (4) @(negedge clk);
    compare_count("credits returned", credits_back, 5);
    report_test("queued_requests", errs_before);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    lfsr      = 16'd46;
    cycle     = 0;
    checks    = 0;
    errors    = 0;
    tests_run = 0;
    clear_scoreboard();
    test_reset_values();
    test_power_up_stream();
    test_power_up_waits();
    test_single_rect();
    test_random_rects();
    test_queued_requests();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+dv
rtl/tft_pkg.sv
rtl/rect_queue.sv
rtl/tft_sequencer.sv
rtl/bus_writer.sv
rtl/tft_top.sv
dv/tb_tft_top.sv

//--- Makefile
# Verilator build and run for the TFT controller testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_tft_top
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
